// File: src/twin_settings.svh
`ifndef TWIN_SETTINGS_SVH
`define TWIN_SETTINGS_SVH

// Main CPU word addresses of the video control registers
`define TWIN_A_SCRA_X  8'd0
`define TWIN_A_SCRA_Y  8'd1
`define TWIN_A_SCRB_X  8'd2
`define TWIN_A_SCRB_Y  8'd3
// Bit 0 hflip, bit 1 vflip, bits 3:2 layer priority
`define TWIN_A_CTRL    8'd4
`define TWIN_A_BANK    8'd5
`define TWIN_A_OBJ_DX  8'd6
`define TWIN_A_OBJ_DY  8'd7
// Sound command, low byte only
`define TWIN_A_LATCH   8'd8

// Number of bytes in the register dump
`define TWIN_DUMP_LEN  11

`endif

// File: src/twin_pkg.sv
`default_nettype none

package twin_pkg;

    typedef logic [7:0] cpu_addr_t;
    typedef logic [15:0] word_t;
    typedef logic [8:0] scroll_t;
    typedef logic [9:0] obj_ofs_t;
    typedef logic [1:0] prio_t;
    // Palette in the upper nibble, colour in the lower one
    typedef logic [7:0] pixel_t;
    // Winning layer id on top of the pixel
    typedef logic [9:0] pal_addr_t;

    typedef struct packed {
        cpu_addr_t addr;
        word_t     data;
    } bus_req_t;

    typedef struct packed {
        scroll_t  scra_x;
        scroll_t  scra_y;
        scroll_t  scrb_x;
        scroll_t  scrb_y;
        logic     hflip;
        logic     vflip;
        prio_t    prio;
        word_t    scr_bank;
        obj_ofs_t obj_dx;
        obj_ofs_t obj_dy;
    } vid_regs_t;

    typedef struct packed {
        pixel_t lyra;
        pixel_t lyrb;
        pixel_t lyro;
    } layer_pix_t;

    typedef enum logic [0:0] { IDLE, HOLD } ctrl_state_e;
    typedef enum logic [1:0] { LID_BACK, LID_A, LID_B, LID_OBJ } layer_id_e;

endpackage

`default_nettype wire

// File: src/twin_bus_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "twin_settings.svh"

module twin_bus_ctrl import twin_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  bus_req_t    bus_req,
    input  logic        bus_valid,
    output logic        bus_ready,
    input  logic        latch_full,
    output logic        reg_we,
    output bus_req_t    reg_req,
    output logic        latch_we,
    output logic [7:0]  latch_data,
    output ctrl_state_e state,
    output logic [7:0]  wr_count
);

    logic accept;
    logic is_latch;
    logic latch_busy;

    assign bus_ready = (state == IDLE);
    assign accept    = bus_valid & bus_ready;
    assign is_latch  = (bus_req.addr == `TWIN_A_LATCH);
    // A write still on its way to the latch counts as full
    assign latch_busy = latch_full | latch_we;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            reg_we   <= 1'b0;
            latch_we <= 1'b0;
            wr_count <= 8'd0;
        end else begin
            reg_we   <= 1'b0;
            latch_we <= 1'b0;
            case (state)
                IDLE: if (accept) begin
                    wr_count <= wr_count + 8'd1;
                    if (!is_latch) begin
                        reg_we <= 1'b1;
                    end else if (latch_busy) begin
                        state <= HOLD;
                    end else begin
                        latch_we <= 1'b1;
                    end
                end
                // Wait for the sound CPU to take the previous byte
                HOLD: if (!latch_full) begin
                    latch_we <= 1'b1;
                    state    <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            reg_req <= bus_req;
            if (is_latch) latch_data <= bus_req.data[7:0];
        end
    end

    a_no_overwrite: assert property (@(posedge clk) disable iff (rst)
        latch_we |-> !latch_full);

endmodule

`default_nettype wire

// File: src/twin_vregs.sv
`timescale 1ns/1ps
`default_nettype none

`include "twin_settings.svh"

module twin_vregs import twin_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      reg_we,
    input  bus_req_t  reg_req,
    output vid_regs_t regs
);

    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '0;
        end else if (reg_we) begin
            case (reg_req.addr)
                `TWIN_A_SCRA_X: regs.scra_x <= reg_req.data[8:0];
                `TWIN_A_SCRA_Y: regs.scra_y <= reg_req.data[8:0];
                `TWIN_A_SCRB_X: regs.scrb_x <= reg_req.data[8:0];
                `TWIN_A_SCRB_Y: regs.scrb_y <= reg_req.data[8:0];
                // Flips and priority share one word
                `TWIN_A_CTRL: begin
                    regs.hflip <= reg_req.data[0];
                    regs.vflip <= reg_req.data[1];
                    regs.prio  <= reg_req.data[3:2];
                end
                `TWIN_A_BANK:   regs.scr_bank <= reg_req.data;
                `TWIN_A_OBJ_DX: regs.obj_dx   <= reg_req.data[9:0];
                `TWIN_A_OBJ_DY: regs.obj_dy   <= reg_req.data[9:0];
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/twin_snd_latch.sv
`timescale 1ns/1ps
`default_nettype none

module twin_snd_latch (
    input  logic       clk,
    input  logic       rst,
    input  logic       latch_we,
    input  logic [7:0] latch_data,
    input  logic       snd_ack,
    output logic [7:0] snd_latch,
    output logic       snd_irq,
    output logic       latch_full
);

    always_ff @(posedge clk) begin
        if (rst) begin
            snd_latch  <= 8'd0;
            latch_full <= 1'b0;
            snd_irq    <= 1'b0;
        end else if (latch_we) begin
            // A new byte wins over an ack on the same edge
            snd_latch  <= latch_data;
            latch_full <= 1'b1;
            snd_irq    <= 1'b1;
        end else if (snd_ack) begin
            latch_full <= 1'b0;
            snd_irq    <= 1'b0;
        end
    end

    a_irq_needs_full: assert property (@(posedge clk) disable iff (rst)
        snd_irq |-> latch_full);

endmodule

`default_nettype wire

// File: src/twin_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module twin_mixer import twin_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  prio_t      prio,
    input  layer_pix_t pix,
    input  logic       pix_valid,
    output pal_addr_t  pal_addr,
    output logic       pal_valid
);

    function automatic pixel_t layer_pixel(input layer_pix_t p, input layer_id_e id);
        case (id)
            LID_A:   return p.lyra;
            LID_B:   return p.lyrb;
            LID_OBJ: return p.lyro;
            default: return '0;
        endcase
    endfunction

    layer_id_e  ord_d [3];
    layer_id_e  ord_q [3];
    logic [3:0] opq_q;
    layer_pix_t pix_q;
    logic       v1;
    layer_id_e  win_id;

    // Rank 0 is the top layer
    always_comb begin
        case (prio)
            2'd0:    ord_d = '{LID_OBJ, LID_A, LID_B};
            2'd1:    ord_d = '{LID_A, LID_OBJ, LID_B};
            2'd2:    ord_d = '{LID_OBJ, LID_B, LID_A};
            default: ord_d = '{LID_B, LID_OBJ, LID_A};
        endcase
    end

    // Stage one, opacity flags indexed by layer id
    always_ff @(posedge clk) begin
        opq_q <= {pix.lyro[3:0] != 4'd0, pix.lyrb[3:0] != 4'd0, pix.lyra[3:0] != 4'd0, 1'b0};
        pix_q <= pix;
        ord_q <= ord_d;
        v1    <= rst ? 1'b0 : pix_valid;
    end

    // Walk from the bottom rank up so the top opaque layer is left
    always_comb begin
        win_id = LID_BACK;
        for (int i = 2; i >= 0; i--) begin
            if (opq_q[ord_q[i]]) win_id = ord_q[i];
        end
    end

    always_ff @(posedge clk) begin
        pal_addr  <= {win_id, layer_pixel(pix_q, win_id)};
        pal_valid <= rst ? 1'b0 : v1;
    end

    a_latency: assert property (@(posedge clk) disable iff (rst)
        pix_valid |-> ##2 pal_valid);

endmodule

`default_nettype wire

// File: src/twin_state_dump.sv
`timescale 1ns/1ps
`default_nettype none

`include "twin_settings.svh"

module twin_state_dump import twin_pkg::*; (
    input  logic        clk,
    input  vid_regs_t   regs,
    input  ctrl_state_e state,
    input  logic [7:0]  wr_count,
    input  logic [7:0]  snd_latch,
    input  logic        latch_full,
    input  logic [3:0]  ioctl_addr,
    input  logic [1:0]  debug_sel,
    output logic [7:0]  ioctl_din,
    output logic [7:0]  debug_view
);

    logic [7:0] dump_map [`TWIN_DUMP_LEN];

    always_comb begin
        dump_map[0]  = regs.scra_x[7:0];
        dump_map[1]  = regs.scrb_x[7:0];
        dump_map[2]  = regs.scra_y[7:0];
        dump_map[3]  = regs.scrb_y[7:0];
        // Ninth scroll bits packed with flips and priority
        dump_map[4]  = {regs.vflip, regs.hflip, regs.prio, regs.scrb_y[8], regs.scra_y[8],
                        regs.scrb_x[8], regs.scra_x[8]};
        dump_map[5]  = regs.scr_bank[7:0];
        dump_map[6]  = regs.scr_bank[15:8];
        dump_map[7]  = regs.obj_dx[7:0];
        dump_map[8]  = {6'd0, regs.obj_dx[9:8]};
        dump_map[9]  = regs.obj_dy[7:0];
        dump_map[10] = {6'd0, regs.obj_dy[9:8]};
    end

    always_ff @(posedge clk) begin
        if (ioctl_addr < `TWIN_DUMP_LEN) begin
            ioctl_din <= dump_map[ioctl_addr];
        end else begin
            ioctl_din <= 8'd0;
        end
    end

    always_ff @(posedge clk) begin
        case (debug_sel)
            2'd0:    debug_view <= {6'd0, latch_full, state == HOLD};
            2'd1:    debug_view <= wr_count;
            2'd2:    debug_view <= snd_latch;
            default: debug_view <= {7'd0, regs.hflip};
        endcase
    end

endmodule

`default_nettype wire

// File: src/twin_game.sv
`timescale 1ns/1ps
`default_nettype none

module twin_game import twin_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    // Main CPU write bus
    input  bus_req_t   bus_req,
    input  logic       bus_valid,
    output logic       bus_ready,
    // Sound CPU side
    input  logic       snd_ack,
    output logic [7:0] snd_latch,
    output logic       snd_irq,
    // Video side
    output vid_regs_t  regs,
    input  layer_pix_t pix,
    input  logic       pix_valid,
    output pal_addr_t  pal_addr,
    output logic       pal_valid,
    // Dump and debug
    input  logic [3:0] ioctl_addr,
    output logic [7:0] ioctl_din,
    input  logic [1:0] debug_sel,
    output logic [7:0] debug_view
);

    logic        reg_we;
    bus_req_t    reg_req;
    logic        latch_we;
    logic [7:0]  latch_data;
    logic        latch_full;
    ctrl_state_e state;
    logic [7:0]  wr_count;

    twin_bus_ctrl u_ctrl (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .bus_req    ( bus_req    ),
        .bus_valid  ( bus_valid  ),
        .bus_ready  ( bus_ready  ),
        .latch_full ( latch_full ),
        .reg_we     ( reg_we     ),
        .reg_req    ( reg_req    ),
        .latch_we   ( latch_we   ),
        .latch_data ( latch_data ),
        .state      ( state      ),
        .wr_count   ( wr_count   )
    );

    twin_vregs u_vregs (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .reg_we     ( reg_we     ),
        .reg_req    ( reg_req    ),
        .regs       ( regs       )
    );

    twin_snd_latch u_latch (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .latch_we   ( latch_we   ),
        .latch_data ( latch_data ),
        .snd_ack    ( snd_ack    ),
        .snd_latch  ( snd_latch  ),
        .snd_irq    ( snd_irq    ),
        .latch_full ( latch_full )
    );

    twin_mixer u_mixer (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .prio       ( regs.prio  ),
        .pix        ( pix        ),
        .pix_valid  ( pix_valid  ),
        .pal_addr   ( pal_addr   ),
        .pal_valid  ( pal_valid  )
    );

    twin_state_dump u_dump (
        .clk        ( clk        ),
        .regs       ( regs       ),
        .state      ( state      ),
        .wr_count   ( wr_count   ),
        .snd_latch  ( snd_latch  ),
        .latch_full ( latch_full ),
        .ioctl_addr ( ioctl_addr ),
        .debug_sel  ( debug_sel  ),
        .ioctl_din  ( ioctl_din  ),
        .debug_view ( debug_view )
    );

endmodule

`default_nettype wire

// File: bench/twin_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module twin_clkgen #(
    parameter int PERIOD_NS  = 4,
    parameter int RST_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        // Release on a falling edge
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: bench/twin_game_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "twin_settings.svh"

module twin_game_tb import twin_pkg::*; ();

    // Cycle budget per test, reset and rounding go into the margin
    localparam int TEST_CYCLES = 50 + 220 + 30 + 180 + 60;

    typedef struct packed {
        logic [31:0] due;
        pal_addr_t   addr;
    } pal_exp_t;

    logic       clk;
    logic       rst;
    bus_req_t   bus_req;
    logic       bus_valid;
    logic       bus_ready;
    logic       snd_ack;
    logic [7:0] snd_latch;
    logic       snd_irq;
    vid_regs_t  regs;
    layer_pix_t pix;
    logic       pix_valid;
    pal_addr_t  pal_addr;
    logic       pal_valid;
    logic [3:0] ioctl_addr;
    logic [7:0] ioctl_din;
    logic [1:0] debug_sel;
    logic [7:0] debug_view;

    vid_regs_t   shadow;
    logic [7:0]  shadow_latch;
    int          wr_total;
    int          checks;
    int          errors;
    int          test_base;
    int          tests_run;
    string       cur_test;
    logic [31:0] cyc;
    pal_exp_t    exp_q [$];

    twin_clkgen #(.PERIOD_NS(4), .RST_CYCLES(8)) clkgen (.clk(clk), .rst(rst));

    twin_game UUT (.*);

    always @(posedge clk) begin
        if (rst) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    function automatic logic [7:0] dump_ref(input vid_regs_t r, input int a);
        case (a)
            0: return r.scra_x[7:0];
            1: return r.scrb_x[7:0];
            2: return r.scra_y[7:0];
            3: return r.scrb_y[7:0];
            4: return {r.vflip, r.hflip, r.prio, r.scrb_y[8], r.scra_y[8],
                       r.scrb_x[8], r.scra_x[8]};
            5: return r.scr_bank[7:0];
            6: return r.scr_bank[15:8];
            7: return r.obj_dx[7:0];
            8: return {6'd0, r.obj_dx[9:8]};
            9: return r.obj_dy[7:0];
            10: return {6'd0, r.obj_dy[9:8]};
            default: return 8'd0;
        endcase
    endfunction

    // Layer ids listed from the top rank down
    function automatic pal_addr_t mix_ref(input prio_t pr, input layer_pix_t p);
        logic [5:0] order;
        logic [1:0] id;
        pixel_t     px;
        case (pr)
            2'd0:    order = {2'd3, 2'd1, 2'd2};
            2'd1:    order = {2'd1, 2'd3, 2'd2};
            2'd2:    order = {2'd3, 2'd2, 2'd1};
            default: order = {2'd2, 2'd3, 2'd1};
        endcase
        for (int i = 0; i < 3; i++) begin
            id = order[5 - 2 * i -: 2];
            px = (id == 2'd1) ? p.lyra : (id == 2'd2) ? p.lyrb : p.lyro;
            if (px[3:0] != 4'd0) return {id, px};
        end
        return '0;
    endfunction

    function automatic pixel_t rand_pixel();
        pixel_t p;
        p[7:4] = 4'($urandom);
        // Roughly a quarter transparent
        p[3:0] = ($urandom % 4 == 0) ? 4'd0 : 4'($urandom % 15 + 1);
        return p;
    endfunction

    task automatic shadow_write(input cpu_addr_t a, input word_t d);
        case (a)
            `TWIN_A_SCRA_X: shadow.scra_x = d[8:0];
            `TWIN_A_SCRA_Y: shadow.scra_y = d[8:0];
            `TWIN_A_SCRB_X: shadow.scrb_x = d[8:0];
            `TWIN_A_SCRB_Y: shadow.scrb_y = d[8:0];
            `TWIN_A_CTRL: begin
                shadow.hflip = d[0];
                shadow.vflip = d[1];
                shadow.prio  = d[3:2];
            end
            `TWIN_A_BANK:   shadow.scr_bank = d;
            `TWIN_A_OBJ_DX: shadow.obj_dx = d[9:0];
            `TWIN_A_OBJ_DY: shadow.obj_dy = d[9:0];
            `TWIN_A_LATCH:  shadow_latch = d[7:0];
            default: ;
        endcase
    endtask

    task automatic check_val(input string what, input logic [79:0] exp_v,
                             input logic [79:0] act_v);
        checks++;
        assert (act_v === exp_v) else begin
            $display("FAIL %s %s expected %0h actual %0h", cur_test, what, exp_v, act_v);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        checks++;
        assert (cond === 1'b1) else begin
            $display("ERROR in %s: %s", cur_test, msg);
            errors++;
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!bus_ready && n < 32) begin
            @(negedge clk);
            n++;
        end
        check_true(bus_ready, "bus_ready stayed low past the timeout");
    endtask

    task automatic bus_write(input cpu_addr_t a, input word_t d);
        @(negedge clk);
        bus_req.addr = a;
        bus_req.data = d;
        bus_valid = 1'b1;
        wait_ready();
        @(negedge clk);
        bus_valid = 1'b0;
        wr_total++;
        shadow_write(a, d);
    endtask

    task automatic read_dump(input logic [3:0] a, output logic [7:0] v);
        @(negedge clk);
        ioctl_addr = a;
        @(negedge clk);
        v = ioctl_din;
    endtask

    task automatic read_debug(input logic [1:0] sel, output logic [7:0] v);
        @(negedge clk);
        debug_sel = sel;
        @(negedge clk);
        v = debug_view;
    endtask

    // Latch is already full here, so the write parks in HOLD until the ack
    task automatic write_latch_with_stall(input logic [7:0] b);
        logic [7:0] prev;
        prev = shadow_latch;
        @(negedge clk);
        debug_sel = 2'd0;
        bus_req.addr = `TWIN_A_LATCH;
        bus_req.data = {8'($urandom), b};
        bus_valid = 1'b1;
        check_true(bus_ready, "bus_ready low before the latch write");
        @(negedge clk);
        bus_valid = 1'b0;
        wr_total++;
        repeat (4) begin
            check_true(!bus_ready, "bus_ready high while the latch is full");
            @(negedge clk);
        end
        check_val("hold status", 8'h03, debug_view);
        check_val("snd_latch during stall", prev, snd_latch);
        snd_ack = 1'b1;
        @(negedge clk);
        snd_ack = 1'b0;
        wait_ready();
        @(negedge clk);
        shadow_latch = b;
        check_val("snd_latch after stall", b, snd_latch);
        check_true(snd_irq, "snd_irq low after the held byte was written");
    endtask

    task automatic finish_test();
        tests_run++;
        $display("test %0d %s finished with %0d errors", tests_run, cur_test,
                 errors - test_base);
        test_base = errors;
    endtask

    // Palette results checked against the queued references
    always @(negedge clk) begin
        if (!rst && pal_valid) begin
            if (exp_q.size() == 0) begin
                check_true(1'b0, "pal_valid high with no pixel in flight");
            end else begin
                check_val("pal_addr", exp_q[0].addr, pal_addr);
                check_val("pal_addr cycle", exp_q[0].due, cyc);
                void'(exp_q.pop_front());
            end
        end else if (!rst && exp_q.size() != 0 && exp_q[0].due <= cyc) begin
            check_true(1'b0, "pal_valid missing for a pixel");
            void'(exp_q.pop_front());
        end
    end

    initial begin
        #(TEST_CYCLES * 4 + 200);
        $display("watchdog expired before the tests finished");
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        cpu_addr_t  a8;
        prio_t      pr;
        layer_pix_t px;
        logic [7:0] v;
        logic [7:0] b;
        int         n;
        void'($urandom(81));
        bus_req = '0;
        bus_valid = 1'b0;
        snd_ack = 1'b0;
        pix = '0;
        pix_valid = 1'b0;
        ioctl_addr = 4'd0;
        debug_sel = 2'd0;
        shadow = '0;
        shadow_latch = 8'd0;
        wr_total = 0;
        checks = 0;
        errors = 0;
        test_base = 0;
        tests_run = 0;
        @(negedge rst);

        cur_test = "reset";
        for (int a = 0; a < 16; a++) begin
            read_dump(4'(a), v);
            check_val($sformatf("dump byte %0d", a), 8'h00, v);
        end
        read_debug(2'd1, v);
        check_val("write count", 8'h00, v);
        check_true(!snd_irq, "snd_irq high after reset");
        check_true(!pal_valid, "pal_valid high after reset");
        check_true(bus_ready, "bus_ready low after reset");
        finish_test();

        cur_test = "register writes";
        for (int k = 0; k < 48; k++) begin
            if (k < 8) begin
                a8 = 8'(k);
            end else begin
                a8 = (k % 4 == 0) ? 8'($urandom) : 8'($urandom % 16);
            end
            if (a8 == `TWIN_A_LATCH) a8 = 8'd9;
            bus_write(a8, 16'($urandom));
            @(negedge clk);
            check_val($sformatf("regs after write to %0h", a8), shadow, regs);
        end
        for (int a = 0; a < 16; a++) begin
            read_dump(4'(a), v);
            check_val($sformatf("dump byte %0d", a), dump_ref(shadow, a), v);
        end
        read_debug(2'd1, v);
        check_val("write count", 8'(wr_total), v);
        finish_test();

        cur_test = "sound latch";
        b = 8'($urandom);
        bus_write(`TWIN_A_LATCH, {8'h00, b});
        @(negedge clk);
        check_true(snd_irq, "snd_irq low after a latch write");
        check_val("snd_latch", b, snd_latch);
        write_latch_with_stall(8'($urandom));
        finish_test();

        cur_test = "mixer";
        for (int blk = 0; blk < 8; blk++) begin
            pr = (blk < 4) ? 2'(blk) : 2'($urandom);
            bus_write(`TWIN_A_CTRL, {12'($urandom), pr, 2'($urandom)});
            @(negedge clk);
            for (int k = 0; k < 16; k++) begin
                px.lyra = rand_pixel();
                px.lyrb = rand_pixel();
                px.lyro = rand_pixel();
                if (k == 5) begin
                    px.lyra[3:0] = 4'd0;
                    px.lyrb[3:0] = 4'd0;
                    px.lyro[3:0] = 4'd0;
                end
                pix = px;
                pix_valid = 1'b1;
                exp_q.push_back('{due: cyc + 2, addr: mix_ref(shadow.prio, px)});
                @(negedge clk);
            end
            pix_valid = 1'b0;
        end
        n = 0;
        while (exp_q.size() != 0 && n < 8) begin
            @(negedge clk);
            n++;
        end
        check_true(exp_q.size() == 0, "palette results missing after the stream");
        finish_test();

        cur_test = "debug view";
        read_debug(2'd0, v);
        check_val("status", 8'h02, v);
        read_debug(2'd1, v);
        check_val("write count", 8'(wr_total), v);
        read_debug(2'd2, v);
        check_val("latch byte", shadow_latch, v);
        read_debug(2'd3, v);
        check_val("hflip", {7'd0, shadow.hflip}, v);
        write_latch_with_stall(8'($urandom));
        read_debug(2'd2, v);
        check_val("latch byte", shadow_latch, v);
        read_debug(2'd1, v);
        check_val("write count", 8'(wr_total), v);
        @(negedge clk);
        snd_ack = 1'b1;
        @(negedge clk);
        snd_ack = 1'b0;
        read_debug(2'd0, v);
        check_val("status", 8'h00, v);
        check_true(!snd_irq, "snd_irq high after the ack");
        finish_test();

        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+src
src/twin_pkg.sv
src/twin_bus_ctrl.sv
src/twin_vregs.sv
src/twin_snd_latch.sv
src/twin_mixer.sv
src/twin_state_dump.sv
src/twin_game.sv
bench/twin_clkgen.sv
bench/twin_game_tb.sv

// File: Bender.yml
package:
  name: twin_game

sources:
  - include_dirs:
      - src
    files:
      - src/twin_pkg.sv
      - src/twin_bus_ctrl.sv
      - src/twin_vregs.sv
      - src/twin_snd_latch.sv
      - src/twin_mixer.sv
      - src/twin_state_dump.sv
      - src/twin_game.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/twin_clkgen.sv
      - bench/twin_game_tb.sv
